/* rtl/mips_defs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// datapath widths
`define MIPS_DATA_W 32
`define MIPS_REG_AW 5
`define MIPS_SEL_W 4

// first fetch after reset
`define MIPS_RESET_PC 32'h0000_0000

// primary opcode field
`define MIPS_OP_SPECIAL 6'b000000
`define MIPS_OP_ADDIU 6'b001001
`define MIPS_OP_ANDI 6'b001100
`define MIPS_OP_ORI 6'b001101
`define MIPS_OP_LUI 6'b001111
`define MIPS_OP_SW 6'b101011

// funct field of SPECIAL
`define MIPS_FN_ADDU 6'b100001
`define MIPS_FN_SUBU 6'b100011
`define MIPS_FN_AND 6'b100100
`define MIPS_FN_OR 6'b100101
`define MIPS_FN_XOR 6'b100110
`define MIPS_FN_SLT 6'b101010

`endif

/* rtl/mips_pkg.sv */
`include "mips_defs.svh"

package mips_pkg;

    // one instruction word seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [`MIPS_REG_AW-1:0] rs;
            logic [`MIPS_REG_AW-1:0] rt;
            logic [`MIPS_REG_AW-1:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0] opcode;
            logic [`MIPS_REG_AW-1:0] rs;
            logic [`MIPS_REG_AW-1:0] rt;
            logic [15:0] imm;
        } i;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_LUI = 4'd6
    } alu_op_e;

    // cpu side of one bus transfer
    typedef struct packed {
        logic valid;
        logic we;
        logic [`MIPS_SEL_W-1:0] sel;
        logic [`MIPS_DATA_W-1:0] addr;
        logic [`MIPS_DATA_W-1:0] wdata;
    } wb_req_t;

    typedef struct packed {
        logic valid;
        alu_op_e alu_op;
        logic [`MIPS_DATA_W-1:0] op_a;
        logic [`MIPS_DATA_W-1:0] op_b;
        logic wreg;
        logic [`MIPS_REG_AW-1:0] waddr;
        logic is_store;
        logic [`MIPS_DATA_W-1:0] store_data;
    } id_ex_t;

    // result doubles as the address of a store
    typedef struct packed {
        logic valid;
        logic wreg;
        logic [`MIPS_REG_AW-1:0] waddr;
        logic [`MIPS_DATA_W-1:0] result;
        logic is_store;
        logic [`MIPS_DATA_W-1:0] store_data;
    } ex_mem_t;

    typedef struct packed {
        logic wreg;
        logic [`MIPS_REG_AW-1:0] waddr;
        logic [`MIPS_DATA_W-1:0] wdata;
    } mem_wb_t;

    typedef struct packed {
        logic wreg;
        logic [`MIPS_REG_AW-1:0] waddr;
        logic [`MIPS_DATA_W-1:0] wdata;
    } fwd_t;

endpackage

/* rtl/wb_master.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module wb_master (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  mips_pkg::wb_req_t        req_i,
    output logic [`MIPS_DATA_W-1:0]  rdata_o,
    output logic                     stall_req_o,
    input  logic [`MIPS_DATA_W-1:0]  wb_dat_i,
    input  logic                     wb_ack_i,
    output logic [`MIPS_DATA_W-1:0]  wb_adr_o,
    output logic [`MIPS_DATA_W-1:0]  wb_dat_o,
    output logic                     wb_we_o,
    output logic [`MIPS_SEL_W-1:0]   wb_sel_o,
    output logic                     wb_stb_o,
    output logic                     wb_cyc_o
);

    // valid bit of the held request is the busy state
    mips_pkg::wb_req_t req_q;
    logic [`MIPS_DATA_W-1:0] rdata_q;
    logic busy;

    assign busy = req_q.valid;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q <= '0;
        end else if (!busy && req_i.valid) begin
            req_q <= req_i;
        end else if (busy && wb_ack_i) begin
            req_q.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (busy && wb_ack_i) begin
            rdata_q <= wb_dat_i;
        end
    end

    // held for the rest of the pipeline once the transfer is over
    assign rdata_o = (busy && wb_ack_i) ? wb_dat_i : rdata_q;

    // request cycle and every wait cycle but not the ack cycle
    assign stall_req_o = busy ? !wb_ack_i : req_i.valid;

    assign wb_cyc_o = busy;
    assign wb_stb_o = busy;
    assign wb_we_o = busy & req_q.we;
    assign wb_sel_o = req_q.sel;
    assign wb_adr_o = req_q.addr;
    assign wb_dat_o = req_q.wdata;

endmodule

/* rtl/fetch_stage.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module fetch_stage (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     dstall_req_i,
    output logic                     stall_o,
    output mips_pkg::inst_u          inst_o,
    output logic                     inst_valid_o,
    input  logic [`MIPS_DATA_W-1:0]  iwb_dat_i,
    input  logic                     iwb_ack_i,
    output logic [`MIPS_DATA_W-1:0]  iwb_adr_o,
    output logic [`MIPS_DATA_W-1:0]  iwb_dat_o,
    output logic                     iwb_we_o,
    output logic [`MIPS_SEL_W-1:0]   iwb_sel_o,
    output logic                     iwb_stb_o,
    output logic                     iwb_cyc_o
);

    logic [`MIPS_DATA_W-1:0] pc_q;
    logic [`MIPS_DATA_W-1:0] fetch_data;
    logic held_q;
    logic istall_req;
    mips_pkg::wb_req_t ireq;

    // no new read while a fetched word waits for the data bus
    always_comb begin
        ireq = '0;
        ireq.valid = !held_q;
        ireq.sel = '1;
        ireq.addr = pc_q;
    end

    wb_master u_iwb (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_i       (ireq),
        .rdata_o     (fetch_data),
        .stall_req_o (istall_req),
        .wb_dat_i    (iwb_dat_i),
        .wb_ack_i    (iwb_ack_i),
        .wb_adr_o    (iwb_adr_o),
        .wb_dat_o    (iwb_dat_o),
        .wb_we_o     (iwb_we_o),
        .wb_sel_o    (iwb_sel_o),
        .wb_stb_o    (iwb_stb_o),
        .wb_cyc_o    (iwb_cyc_o)
    );

    assign stall_o = istall_req | dstall_req_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `MIPS_RESET_PC;
            held_q <= 1'b0;
            inst_o <= '0;
            inst_valid_o <= 1'b0;
        end else if (stall_o) begin
            if (iwb_ack_i) begin
                held_q <= 1'b1;
            end
        end else begin
            pc_q <= pc_q + `MIPS_DATA_W'(4);
            held_q <= 1'b0;
            inst_o <= fetch_data;
            inst_valid_o <= 1'b1;
        end
    end

endmodule

/* rtl/regfile.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module regfile (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  mips_pkg::mem_wb_t        wb_i,
    input  logic [`MIPS_REG_AW-1:0]  raddr1_i,
    input  logic [`MIPS_REG_AW-1:0]  raddr2_i,
    output logic [`MIPS_DATA_W-1:0]  rdata1_o,
    output logic [`MIPS_DATA_W-1:0]  rdata2_o
);

    // $0 has no storage
    logic [`MIPS_DATA_W-1:0] regs [1:31];

    function automatic logic [`MIPS_DATA_W-1:0] read_port(
        input logic [`MIPS_REG_AW-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end
        // same-cycle writeback passes straight through
        if (wb_i.wreg && wb_i.waddr == addr) begin
            return wb_i.wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs <= '{default: '0};
        end else if (wb_i.wreg && wb_i.waddr != '0) begin
            regs[wb_i.waddr] <= wb_i.wdata;
        end
    end

    assign rdata1_o = read_port(raddr1_i);
    assign rdata2_o = read_port(raddr2_i);

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module decode_stage (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               stall_i,
    input  mips_pkg::inst_u    inst_i,
    input  logic               inst_valid_i,
    input  mips_pkg::fwd_t     ex_fwd_i,
    input  mips_pkg::fwd_t     mem_fwd_i,
    input  mips_pkg::mem_wb_t  wb_i,
    output mips_pkg::id_ex_t   id_ex_o
);

    logic [`MIPS_DATA_W-1:0] rs_rf;
    logic [`MIPS_DATA_W-1:0] rt_rf;
    logic [`MIPS_DATA_W-1:0] rs_val;
    logic [`MIPS_DATA_W-1:0] rt_val;
    logic [`MIPS_DATA_W-1:0] imm_sext;
    logic [`MIPS_DATA_W-1:0] imm_zext;
    mips_pkg::id_ex_t id_ex_d;

    regfile u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_i     (wb_i),
        .raddr1_i (inst_i.r.rs),
        .raddr2_i (inst_i.r.rt),
        .rdata1_o (rs_rf),
        .rdata2_o (rt_rf)
    );

    // youngest producer wins and $0 is never forwarded
    function automatic logic [`MIPS_DATA_W-1:0] fwd_mux(
        input logic [`MIPS_REG_AW-1:0] addr,
        input logic [`MIPS_DATA_W-1:0] rf_data
    );
        logic [`MIPS_DATA_W-1:0] val;
        val = rf_data;
        if (addr != '0 && mem_fwd_i.wreg && mem_fwd_i.waddr == addr) begin
            val = mem_fwd_i.wdata;
        end
        if (addr != '0 && ex_fwd_i.wreg && ex_fwd_i.waddr == addr) begin
            val = ex_fwd_i.wdata;
        end
        return val;
    endfunction

    assign rs_val = fwd_mux(inst_i.r.rs, rs_rf);
    assign rt_val = fwd_mux(inst_i.r.rt, rt_rf);
    assign imm_sext = {{16{inst_i.i.imm[15]}}, inst_i.i.imm};
    assign imm_zext = {16'h0000, inst_i.i.imm};

    always_comb begin
        id_ex_d = '0;
        id_ex_d.valid = inst_valid_i;
        id_ex_d.wreg = inst_valid_i;
        id_ex_d.alu_op = mips_pkg::ALU_ADD;
        id_ex_d.op_a = rs_val;
        id_ex_d.op_b = rt_val;
        id_ex_d.waddr = inst_i.r.rd;
        id_ex_d.store_data = rt_val;
        case (inst_i.r.opcode)
            `MIPS_OP_SPECIAL: begin
                case (inst_i.r.funct)
                    `MIPS_FN_ADDU: id_ex_d.alu_op = mips_pkg::ALU_ADD;
                    `MIPS_FN_SUBU: id_ex_d.alu_op = mips_pkg::ALU_SUB;
                    `MIPS_FN_AND: id_ex_d.alu_op = mips_pkg::ALU_AND;
                    `MIPS_FN_OR: id_ex_d.alu_op = mips_pkg::ALU_OR;
                    `MIPS_FN_XOR: id_ex_d.alu_op = mips_pkg::ALU_XOR;
                    `MIPS_FN_SLT: id_ex_d.alu_op = mips_pkg::ALU_SLT;
                    default: begin
                        id_ex_d.valid = 1'b0;
                        id_ex_d.wreg = 1'b0;
                    end
                endcase
            end
            `MIPS_OP_ADDIU: begin
                id_ex_d.op_b = imm_sext;
                id_ex_d.waddr = inst_i.i.rt;
            end
            `MIPS_OP_ANDI: begin
                id_ex_d.alu_op = mips_pkg::ALU_AND;
                id_ex_d.op_b = imm_zext;
                id_ex_d.waddr = inst_i.i.rt;
            end
            `MIPS_OP_ORI: begin
                id_ex_d.alu_op = mips_pkg::ALU_OR;
                id_ex_d.op_b = imm_zext;
                id_ex_d.waddr = inst_i.i.rt;
            end
            `MIPS_OP_LUI: begin
                id_ex_d.alu_op = mips_pkg::ALU_LUI;
                id_ex_d.op_b = imm_zext;
                id_ex_d.waddr = inst_i.i.rt;
            end
            // address from the ALU with rt riding along as data
            `MIPS_OP_SW: begin
                id_ex_d.op_b = imm_sext;
                id_ex_d.wreg = 1'b0;
                id_ex_d.is_store = inst_valid_i;
            end
            default: begin
                id_ex_d.valid = 1'b0;
                id_ex_d.wreg = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o <= '0;
        end else if (!stall_i) begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module execute_stage (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               stall_i,
    input  mips_pkg::id_ex_t   id_ex_i,
    output mips_pkg::fwd_t     ex_fwd_o,
    output mips_pkg::ex_mem_t  ex_mem_o
);

    logic [`MIPS_DATA_W-1:0] result;
    logic slt;

    assign slt = $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b);

    always_comb begin
        case (id_ex_i.alu_op)
            mips_pkg::ALU_ADD: result = id_ex_i.op_a + id_ex_i.op_b;
            mips_pkg::ALU_SUB: result = id_ex_i.op_a - id_ex_i.op_b;
            mips_pkg::ALU_AND: result = id_ex_i.op_a & id_ex_i.op_b;
            mips_pkg::ALU_OR: result = id_ex_i.op_a | id_ex_i.op_b;
            mips_pkg::ALU_XOR: result = id_ex_i.op_a ^ id_ex_i.op_b;
            mips_pkg::ALU_SLT: result = {{(`MIPS_DATA_W-1){1'b0}}, slt};
            mips_pkg::ALU_LUI: result = {id_ex_i.op_b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // unregistered for distance-one dependencies
    assign ex_fwd_o.wreg = id_ex_i.valid & id_ex_i.wreg;
    assign ex_fwd_o.waddr = id_ex_i.waddr;
    assign ex_fwd_o.wdata = result;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_o <= '0;
        end else if (!stall_i) begin
            ex_mem_o.valid <= id_ex_i.valid;
            ex_mem_o.wreg <= id_ex_i.valid & id_ex_i.wreg;
            ex_mem_o.waddr <= id_ex_i.waddr;
            ex_mem_o.result <= result;
            ex_mem_o.is_store <= id_ex_i.valid & id_ex_i.is_store;
            ex_mem_o.store_data <= id_ex_i.store_data;
        end
    end

endmodule

/* rtl/mem_stage.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mem_stage (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  logic                     stall_i,
    input  mips_pkg::ex_mem_t        ex_mem_i,
    output mips_pkg::fwd_t           mem_fwd_o,
    output mips_pkg::mem_wb_t        mem_wb_o,
    output logic                     stall_req_o,
    input  logic [`MIPS_DATA_W-1:0]  dwb_dat_i,
    input  logic                     dwb_ack_i,
    output logic [`MIPS_DATA_W-1:0]  dwb_adr_o,
    output logic [`MIPS_DATA_W-1:0]  dwb_dat_o,
    output logic                     dwb_we_o,
    output logic [`MIPS_SEL_W-1:0]   dwb_sel_o,
    output logic                     dwb_stb_o,
    output logic                     dwb_cyc_o
);

    mips_pkg::wb_req_t dreq;
    logic store_done_q;

    // store already acked while fetch still holds the pipeline
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            store_done_q <= 1'b0;
        end else begin
            store_done_q <= stall_i & (store_done_q | dwb_ack_i);
        end
    end

    always_comb begin
        dreq.valid = ex_mem_i.valid & ex_mem_i.is_store & !store_done_q;
        dreq.we = 1'b1;
        dreq.sel = '1;
        dreq.addr = ex_mem_i.result;
        dreq.wdata = ex_mem_i.store_data;
    end

    wb_master u_dwb (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_i       (dreq),
        .rdata_o     (),
        .stall_req_o (stall_req_o),
        .wb_dat_i    (dwb_dat_i),
        .wb_ack_i    (dwb_ack_i),
        .wb_adr_o    (dwb_adr_o),
        .wb_dat_o    (dwb_dat_o),
        .wb_we_o     (dwb_we_o),
        .wb_sel_o    (dwb_sel_o),
        .wb_stb_o    (dwb_stb_o),
        .wb_cyc_o    (dwb_cyc_o)
    );

    assign mem_fwd_o.wreg = ex_mem_i.valid & ex_mem_i.wreg;
    assign mem_fwd_o.waddr = ex_mem_i.waddr;
    assign mem_fwd_o.wdata = ex_mem_i.result;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_wb_o <= '0;
        end else if (!stall_i) begin
            mem_wb_o.wreg <= mem_fwd_o.wreg;
            mem_wb_o.waddr <= mem_fwd_o.waddr;
            mem_wb_o.wdata <= mem_fwd_o.wdata;
        end
    end

endmodule

/* rtl/mips_core.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_core (
    input  logic                     clk,
    input  logic                     arst_n_i,
    // instruction bus
    input  logic [`MIPS_DATA_W-1:0]  iwb_dat_i,
    input  logic                     iwb_ack_i,
    output logic [`MIPS_DATA_W-1:0]  iwb_adr_o,
    output logic [`MIPS_DATA_W-1:0]  iwb_dat_o,
    output logic                     iwb_we_o,
    output logic [`MIPS_SEL_W-1:0]   iwb_sel_o,
    output logic                     iwb_stb_o,
    output logic                     iwb_cyc_o,
    // data bus
    input  logic [`MIPS_DATA_W-1:0]  dwb_dat_i,
    input  logic                     dwb_ack_i,
    output logic [`MIPS_DATA_W-1:0]  dwb_adr_o,
    output logic [`MIPS_DATA_W-1:0]  dwb_dat_o,
    output logic                     dwb_we_o,
    output logic [`MIPS_SEL_W-1:0]   dwb_sel_o,
    output logic                     dwb_stb_o,
    output logic                     dwb_cyc_o
);

    logic stall;
    logic dstall_req;
    logic inst_valid;
    mips_pkg::inst_u inst;
    mips_pkg::id_ex_t id_ex;
    mips_pkg::ex_mem_t ex_mem;
    mips_pkg::mem_wb_t mem_wb;
    mips_pkg::fwd_t ex_fwd;
    mips_pkg::fwd_t mem_fwd;

    fetch_stage u_fetch (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .dstall_req_i (dstall_req),
        .stall_o      (stall),
        .inst_o       (inst),
        .inst_valid_o (inst_valid),
        .iwb_dat_i    (iwb_dat_i),
        .iwb_ack_i    (iwb_ack_i),
        .iwb_adr_o    (iwb_adr_o),
        .iwb_dat_o    (iwb_dat_o),
        .iwb_we_o     (iwb_we_o),
        .iwb_sel_o    (iwb_sel_o),
        .iwb_stb_o    (iwb_stb_o),
        .iwb_cyc_o    (iwb_cyc_o)
    );

    decode_stage u_decode (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .stall_i      (stall),
        .inst_i       (inst),
        .inst_valid_i (inst_valid),
        .ex_fwd_i     (ex_fwd),
        .mem_fwd_i    (mem_fwd),
        .wb_i         (mem_wb),
        .id_ex_o      (id_ex)
    );

    execute_stage u_execute (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (stall),
        .id_ex_i  (id_ex),
        .ex_fwd_o (ex_fwd),
        .ex_mem_o (ex_mem)
    );

    mem_stage u_mem (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .stall_i     (stall),
        .ex_mem_i    (ex_mem),
        .mem_fwd_o   (mem_fwd),
        .mem_wb_o    (mem_wb),
        .stall_req_o (dstall_req),
        .dwb_dat_i   (dwb_dat_i),
        .dwb_ack_i   (dwb_ack_i),
        .dwb_adr_o   (dwb_adr_o),
        .dwb_dat_o   (dwb_dat_o),
        .dwb_we_o    (dwb_we_o),
        .dwb_sel_o   (dwb_sel_o),
        .dwb_stb_o   (dwb_stb_o),
        .dwb_cyc_o   (dwb_cyc_o)
    );

endmodule

/* testbench/mips_core_props.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_core_props (
    input logic                     clk,
    input logic                     arst_n_i,
    input logic                     iwb_ack_i,
    input logic [`MIPS_DATA_W-1:0]  iwb_adr_o,
    input logic                     iwb_we_o,
    input logic [`MIPS_SEL_W-1:0]   iwb_sel_o,
    input logic                     iwb_stb_o,
    input logic                     iwb_cyc_o,
    input logic                     dwb_ack_i,
    input logic [`MIPS_DATA_W-1:0]  dwb_adr_o,
    input logic [`MIPS_DATA_W-1:0]  dwb_dat_o,
    input logic                     dwb_we_o,
    input logic [`MIPS_SEL_W-1:0]   dwb_sel_o,
    input logic                     dwb_stb_o,
    input logic                     dwb_cyc_o
);

    // request must stay put until the slave acks
    a_ireq_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        iwb_stb_o && !iwb_ack_i |=> $stable({iwb_stb_o, iwb_adr_o, iwb_we_o, iwb_sel_o}))
        else $error("instruction bus request changed before ack");

    a_dreq_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        dwb_stb_o && !dwb_ack_i |=>
        $stable({dwb_stb_o, dwb_adr_o, dwb_dat_o, dwb_we_o, dwb_sel_o}))
        else $error("data bus request changed before ack");

    a_istb_cyc: assert property (@(posedge clk) disable iff (!arst_n_i)
        iwb_stb_o |-> iwb_cyc_o)
        else $error("iwb stb without cyc");

    a_dstb_cyc: assert property (@(posedge clk) disable iff (!arst_n_i)
        dwb_stb_o |-> dwb_cyc_o)
        else $error("dwb stb without cyc");

    a_iwb_no_write: assert property (@(posedge clk) disable iff (!arst_n_i)
        !iwb_we_o)
        else $error("instruction bus asserted we");

endmodule

bind mips_core mips_core_props u_props (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .iwb_ack_i (iwb_ack_i),
    .iwb_adr_o (iwb_adr_o),
    .iwb_we_o  (iwb_we_o),
    .iwb_sel_o (iwb_sel_o),
    .iwb_stb_o (iwb_stb_o),
    .iwb_cyc_o (iwb_cyc_o),
    .dwb_ack_i (dwb_ack_i),
    .dwb_adr_o (dwb_adr_o),
    .dwb_dat_o (dwb_dat_o),
    .dwb_we_o  (dwb_we_o),
    .dwb_sel_o (dwb_sel_o),
    .dwb_stb_o (dwb_stb_o),
    .dwb_cyc_o (dwb_cyc_o)
);

/* testbench/mips_core_tb.sv */
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_core_tb;

    logic clk;
    logic arst_n_i;
    logic [31:0] iwb_dat_i;
    logic iwb_ack_i;
    logic [31:0] iwb_adr_o;
    logic [31:0] iwb_dat_o;
    logic iwb_we_o;
    logic [3:0] iwb_sel_o;
    logic iwb_stb_o;
    logic iwb_cyc_o;
    logic [31:0] dwb_dat_i;
    logic dwb_ack_i;
    logic [31:0] dwb_adr_o;
    logic [31:0] dwb_dat_o;
    logic dwb_we_o;
    logic [3:0] dwb_sel_o;
    logic dwb_stb_o;
    logic dwb_cyc_o;

    integer seed;
    integer errors;
    integer iwait;
    integer dwait;
    logic [31:0] exp_pc;
    logic [31:0] prog_q[$];
    logic [31:0] exp_addr_q[$];
    logic [31:0] exp_data_q[$];
    string exp_name_q[$];
    logic [31:0] st_addr_q[$];
    logic [31:0] st_data_q[$];
    logic [3:0] st_sel_q[$];

    mips_core UUT (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] enc_r(input logic [4:0] rd, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [5:0] fn);
        return {`MIPS_OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // program word plus the store it should produce
    task automatic add(input logic [31:0] inst, input bit is_sw, input logic [31:0] addr,
                       input logic [31:0] data, input string name);
        prog_q.push_back(inst);
        if (is_sw) begin
            exp_addr_q.push_back(addr);
            exp_data_q.push_back(data);
            exp_name_q.push_back(name);
        end
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // instruction memory returns NOP past the end of the table
    always @(posedge clk) begin
        if (iwb_ack_i) begin
            iwb_ack_i <= 1'b0;
        end else if (iwb_stb_o) begin
            if (iwait == 0) begin
                iwb_ack_i <= 1'b1;
                iwb_dat_i <= ((iwb_adr_o >> 2) < prog_q.size()) ? prog_q[iwb_adr_o >> 2] : '0;
                iwait <= $random(seed) & 3;
            end else begin
                iwait <= iwait - 1;
            end
        end
    end

    // data slave logs each acked write
    always @(posedge clk) begin
        if (dwb_ack_i) begin
            dwb_ack_i <= 1'b0;
            st_addr_q.push_back(dwb_adr_o);
            st_data_q.push_back(dwb_dat_o);
            st_sel_q.push_back(dwb_we_o ? dwb_sel_o : 4'h0);
        end else if (dwb_stb_o) begin
            if (dwait == 0) begin
                dwb_ack_i <= 1'b1;
                dwait <= $random(seed) & 3;
            end else begin
                dwait <= dwait - 1;
            end
        end
    end

    // fetch order and byte selects
    always @(posedge clk) begin
        if (arst_n_i && iwb_stb_o && iwb_ack_i) begin
            check("fetch address", exp_pc, iwb_adr_o);
            check("fetch sel", 32'hf, 32'(iwb_sel_o));
            exp_pc <= exp_pc + 32'd4;
        end
    end

    initial begin
        integer limit;
        #1;
        // program length x worst wait x stages plus reset and margin
        limit = 16 + prog_q.size() * 4 * 5 + 200;
        #(limit * 100);
        $display("timeout: stores did not finish after %0d cycles, errors: %0d", limit, errors);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        integer n;
        seed = 32'h833e3019;
        errors = 0;
        clk = 1'b0;
        arst_n_i = 1'b0;
        iwb_dat_i = '0;
        iwb_ack_i = 1'b0;
        dwb_dat_i = '0;
        dwb_ack_i = 1'b0;
        exp_pc = `MIPS_RESET_PC;
        iwait = $random(seed) & 3;
        dwait = $random(seed) & 3;

        add(enc_i(`MIPS_OP_LUI, 1, 0, 16'h8000), 0, 0, 0, "lui");
        add(enc_i(`MIPS_OP_ORI, 1, 1, 16'h0005), 0, 0, 0, "ori");
        add(enc_i(`MIPS_OP_ORI, 2, 0, 16'h0003), 0, 0, 0, "ori");
        add(enc_r(3, 1, 2, `MIPS_FN_ADDU), 0, 0, 0, "addu");
        add(enc_i(`MIPS_OP_SW, 3, 0, 16'h0100), 1, 32'h100, 32'h8000_0008, "addu");
        add(enc_r(4, 2, 1, `MIPS_FN_SUBU), 0, 0, 0, "subu");
        add(enc_i(`MIPS_OP_SW, 4, 0, 16'h0104), 1, 32'h104, 32'h7fff_fffe, "subu");
        add(enc_r(5, 1, 2, `MIPS_FN_AND), 0, 0, 0, "and");
        add(enc_i(`MIPS_OP_SW, 5, 0, 16'h0108), 1, 32'h108, 32'h0000_0001, "and");
        add(enc_r(6, 1, 2, `MIPS_FN_OR), 0, 0, 0, "or");
        add(enc_i(`MIPS_OP_SW, 6, 0, 16'h010c), 1, 32'h10c, 32'h8000_0007, "or");
        add(enc_r(7, 1, 2, `MIPS_FN_XOR), 0, 0, 0, "xor");
        add(enc_i(`MIPS_OP_SW, 7, 0, 16'h0110), 1, 32'h110, 32'h8000_0006, "xor");
        add(enc_r(8, 1, 2, `MIPS_FN_SLT), 0, 0, 0, "slt");
        add(enc_r(9, 2, 1, `MIPS_FN_SLT), 0, 0, 0, "slt");
        add(enc_i(`MIPS_OP_SW, 8, 0, 16'h0114), 1, 32'h114, 32'h0000_0001, "slt neg<pos");
        add(enc_i(`MIPS_OP_SW, 9, 0, 16'h0118), 1, 32'h118, 32'h0000_0000, "slt pos<neg");
        add(enc_i(`MIPS_OP_ADDIU, 10, 2, 16'hfffb), 0, 0, 0, "addiu");
        add(enc_i(`MIPS_OP_SW, 10, 0, 16'h011c), 1, 32'h11c, 32'hffff_fffe, "addiu neg");
        add(enc_i(`MIPS_OP_ORI, 11, 0, 16'hffff), 0, 0, 0, "ori");
        add(enc_i(`MIPS_OP_ANDI, 12, 1, 16'h8005), 0, 0, 0, "andi");
        add(enc_i(`MIPS_OP_SW, 11, 0, 16'h0120), 1, 32'h120, 32'h0000_ffff, "ori zext");
        add(enc_i(`MIPS_OP_SW, 12, 0, 16'h0124), 1, 32'h124, 32'h0000_0005, "andi zext");
        add(enc_i(`MIPS_OP_LUI, 13, 0, 16'h1234), 0, 0, 0, "lui");
        add(enc_i(`MIPS_OP_SW, 13, 0, 16'h0128), 1, 32'h128, 32'h1234_0000, "lui");
        add(enc_i(`MIPS_OP_ADDIU, 0, 2, 16'h0007), 0, 0, 0, "write r0");
        add(enc_i(`MIPS_OP_SW, 0, 0, 16'h012c), 1, 32'h12c, 32'h0000_0000, "r0 stays zero");
        add(enc_i(`MIPS_OP_ADDIU, 14, 0, 16'h0200), 0, 0, 0, "base");
        add(enc_i(`MIPS_OP_SW, 2, 14, 16'hfffc), 1, 32'h1fc, 32'h0000_0003, "sw neg offset");
        add(enc_r(15, 14, 14, `MIPS_FN_ADDU), 0, 0, 0, "addu");
        add(enc_i(`MIPS_OP_SW, 15, 15, 16'h0000), 1, 32'h400, 32'h0000_0400, "fwd base+data");

        // outputs sampled mid-cycle once the edge has settled
        repeat (16) begin
            @(negedge clk);
            check("reset iwb cyc/stb", 0, 32'({iwb_cyc_o, iwb_stb_o}));
            check("reset dwb cyc/stb/we", 0, 32'({dwb_cyc_o, dwb_stb_o, dwb_we_o}));
        end
        @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        check("post-reset iwb cyc/stb", 0, 32'({iwb_cyc_o, iwb_stb_o}));
        check("post-reset dwb cyc/stb/we", 0, 32'({dwb_cyc_o, dwb_stb_o, dwb_we_o}));

        n = exp_addr_q.size();
        while (st_addr_q.size() < n) begin
            @(posedge clk);
        end
        // room for a duplicate to show up
        repeat (60) @(posedge clk);

        for (int i = 0; i < n; i++) begin
            check({exp_name_q[i], " addr"}, exp_addr_q[i], st_addr_q[i]);
            check({exp_name_q[i], " data"}, exp_data_q[i], st_data_q[i]);
            check({exp_name_q[i], " sel"}, 32'hf, 32'(st_sel_q[i]));
        end
        if (st_addr_q.size() != n) begin
            $display("got %0d stores, expected %0d", st_addr_q.size(), n);
            errors++;
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* mips_core.f */
+incdir+rtl
rtl/mips_pkg.sv
rtl/wb_master.sv
rtl/fetch_stage.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/mips_core.sv
testbench/mips_core_props.sv
testbench/mips_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := mips_core_tb
FILELIST  := mips_core.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
